// File: bench/microOpExpanderTb.sv
// Random-stimulus testbench for the micro-op expander; run it through src.f with the bench as top
`timescale 1ns/1ps

module microOpExpanderTb;

	localparam int clkPeriod = 20;
	localparam int numInstr = 400;
	localparam int maxBeats = 20; // Generous beats per instruction, stalls included
	localparam int timeLimit = numInstr * maxBeats * clkPeriod * 2;

	logic clk;
	logic reset;
	logic stall;
	isaPkg::instrWord instr;
	isaPkg::nzcvFlags flags;
	isaPkg::instrWord uop;
	uopPkg::uopCtrl ctrl;

	int uopErrors;
	int ctrlErrors;
	int checks;
	int issued;           // Instructions started so far
	int mBeat;            // Model beat index within the current series
	logic [15:0] mList;   // Model copy of registers still to load
	logic [15:0] nextList;
	bit busy;             // Model is mid-series
	bit prevStall;
	bit done;             // Current beat closes the series
	isaPkg::instrWord expUop;
	isaPkg::instrWord prevUop;
	uopPkg::uopCtrl expCtrl;
	uopPkg::uopCtrl prevCtrl;

	microOpExpander u_microOpExpander (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.instr (instr),
		.flags (flags),
		.uop   (uop),
		.ctrl  (ctrl)
	);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkInstr(input isaPkg::instrWord got, input isaPkg::instrWord exp,
			input string what);
		checks++;
		if (got !== exp) begin
			uopErrors++;
			$display("Fail %0t: %s uop %h, expected %h (instr %h)", $time, what, got, exp, instr);
		end
	endtask

	task automatic checkCtrl(input uopPkg::uopCtrl got, input uopPkg::uopCtrl exp,
			input string what);
		checks++;
		if (got !== exp) begin
			ctrlErrors++;
			$display("Fail %0t: %s ctrl %b, expected %b (instr %h)", $time, what, got, exp, instr);
		end
	endtask

	// Class tests in decode priority order
	function automatic isaPkg::instrClass classifyWord(input isaPkg::instrWord w);
		bit bx;
		bx = (w[27:6] == 22'b0001_0010_1111_1111_1111_00); // BX family
		if (w[27:25] == 3'b000 && !w[7] && w[4] && !bx) return isaPkg::clsRsr;
		if (w[21] && w[7:4] == 4'b1001) begin
			return w[23] ? isaPkg::clsMulAccLong : isaPkg::clsMulAccShort;
		end
		if (w[27:25] == 3'b100 && w[20] && w[15:0] != 16'b0) return isaPkg::clsLoadMultiple;
		if (w[27:24] == 4'b1011) return isaPkg::clsBranchLink;
		return isaPkg::clsPlain;
	endfunction

	// Even codes test a flag term, odd codes invert it
	function automatic bit condHolds(input logic [3:0] c, input isaPkg::nzcvFlags f);
		bit r;
		case (c[3:1])
			3'd0: r = f.z;
			3'd1: r = f.c;
			3'd2: r = f.n;
			3'd3: r = f.v;
			3'd4: r = f.c && !f.z;
			3'd5: r = (f.n == f.v);
			3'd6: r = !f.z && (f.n == f.v);
			default: r = 1'b1;
		endcase
		if (c[3:1] == 3'd7) return !c[0]; // AL always, NV never
		return r ^ c[0];
	endfunction

	function automatic isaPkg::instrWord randomInstr();
		isaPkg::instrWord w;
		w = $urandom; // Kind 0 keeps a fully random word
		case ($urandom_range(0, 5))
			1: begin
				w[27:25] = 3'b000; // RSR
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			2: begin
				w[27:24] = 4'b0000; // MLA or long accumulate
				w[21] = 1'b1;
				w[7:4] = 4'b1001;
			end
			3: w[27:24] = 4'b1011; // BL
			4: begin
				w[27:25] = 3'b100; // LDM, mostly AL so series run to the end
				w[20] = 1'b1;
				if ($urandom_range(0, 3) != 0) w[31:28] = 4'hE;
				if ($urandom_range(0, 9) == 0) w[15:0] = 16'b0;
			end
			5: w[27:25] = 3'b001; // Immediate data processing
			default: ;
		endcase
		return w;
	endfunction

	// Expected word and controls for the current beat of the held instruction
	task automatic expectBeat(output isaPkg::instrWord eu, output uopPkg::uopCtrl ec,
			output bit last, output logic [15:0] rest);
		logic [15:0] lst;
		int n;
		int s;
		int low;
		eu = instr;
		ec = '0;
		last = 1'b1;
		rest = 16'b0;
		low = 0;
		case (classifyWord(instr))
			isaPkg::clsRsr: begin
				ec.instrMux = 1'b1;
				last = (mBeat != 0);
				if (mBeat == 0) begin
					eu[24:21] = isaPkg::movOp; // MOV Rz, shifted operand
					eu[20:16] = 5'b0;
					eu[15:12] = uopPkg::rzReg;
					ec.noFlagUpdate = 1'b1;
					ec.uopStall = 1'b1;
					ec.rz = uopPkg::rzShiftSrc;
				end else begin
					eu[11:0] = {8'b0, uopPkg::rzReg}; // Original op reading Rz
					ec.prevRsr = 1'b1;
					ec.rz = uopPkg::rzOperandB;
				end
			end
			isaPkg::clsMulAccShort, isaPkg::clsMulAccLong: begin
				ec.instrMux = 1'b1;
				last = (mBeat != 0);
				if (mBeat == 0) begin
					eu[23] = 1'b0; // MUL into Rz
					eu[21] = 1'b0;
					eu[19:16] = uopPkg::rzReg;
					eu[15:12] = 4'b0;
					ec.uopStall = 1'b1;
					ec.keepV = 1'b1;
					ec.rz = uopPkg::rzShiftSrc;
				end else begin
					if (instr[23]) begin
						eu[23:21] = 3'b101; // Accumulate-long word
						eu[11:8] = instr[15:12];
						eu[3:0] = instr[19:16];
					end else begin
						eu = '0; // ADD Rd, Rz, Ra
						eu[31:28] = instr[31:28];
						eu[24:21] = isaPkg::addOp;
						eu[20] = instr[21];
						eu[19:16] = uopPkg::rzReg;
						eu[15:12] = instr[19:16];
						eu[3:0] = instr[15:12];
						ec.rz = uopPkg::rzOperandA;
					end
					ec.noFlagUpdate = 1'b1;
					ec.prevRsr = 1'b1;
				end
			end
			isaPkg::clsBranchLink: begin
				ec.instrMux = 1'b1;
				last = (mBeat != 0);
				if (mBeat == 0) begin
					eu = '0; // MOV LR, PC
					eu[31:28] = instr[31:28];
					eu[24:21] = isaPkg::movOp;
					eu[15:12] = uopPkg::linkReg;
					eu[3:0] = uopPkg::pcReg;
					ec.uopStall = 1'b1;
				end else begin
					eu[24] = 1'b0; // Plain branch
				end
			end
			isaPkg::clsLoadMultiple: begin
				n = $countones(instr[15:0]);
				lst = (mBeat == 0) ? instr[15:0] : mList;
				case (instr[24:23])
					2'b00: s = -4 * (n - 1); // DA
					2'b01: s = 0;            // IA
					2'b10: s = -4 * n;       // DB
					default: s = 4;          // IB
				endcase
				s = s + 4 * mBeat;
				for (int i = 15; i >= 0; i--) begin
					if (lst[i]) low = i;
				end
				eu = '0;
				eu[31:28] = instr[31:28];
				if (mBeat != 0 && !condHolds(instr[31:28], flags)) begin
					eu[27:25] = 3'b001; // Abort as harmless ADD
					eu[24:21] = isaPkg::addOp;
					ec.noFlagUpdate = 1'b1;
				end else begin
					last = ($countones(lst) == 1);
					rest = lst & ~(16'b1 << low);
					eu[27:24] = 4'b0101; // Single word load, pre-indexed
					eu[23] = (s >= 0);
					eu[20] = 1'b1;
					eu[19:16] = instr[19:16];
					eu[15:12] = 4'(low);
					eu[11:0] = 12'((s < 0) ? -s : s);
					ec.instrMux = 1'b1;
					ec.noFlagUpdate = 1'b1;
					ec.uopStall = !last;
					ec.blockForward = (mBeat != 0);
				end
			end
			default: ; // Plain passes through
		endcase
	endtask

	initial begin
		#(timeLimit);
		$display("Timeout: no end of run after %0d ns, the expander or bench hung", timeLimit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(90118));
		clk = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		instr = '0;
		flags = '0;
		uopErrors = 0;
		ctrlErrors = 0;
		checks = 0;
		issued = 0;
		mBeat = 0;
		mList = '0;
		busy = 1'b0;
		prevStall = 1'b0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		checkInstr(uop, instr, "after reset");
		checkCtrl(ctrl, '0, "after reset");
		while (issued < numInstr || busy || prevStall) begin
			@(posedge clk);
			#1;
			if (!prevStall) begin
				if (!busy) begin
					instr = randomInstr(); // New instruction with fresh flags
					flags = 4'($urandom);
					issued++;
				end else if (classifyWord(instr) == isaPkg::clsLoadMultiple
						&& $urandom_range(0, 3) == 0) begin
					flags = 4'($urandom); // Condition may fail mid-series
				end
			end
			stall = ($urandom_range(0, 99) < 20);
			@(negedge clk);
			expectBeat(expUop, expCtrl, done, nextList);
			checkInstr(uop, expUop, "model");
			checkCtrl(ctrl, expCtrl, "model");
			if (prevStall) begin
				checkInstr(uop, prevUop, "held during stall");
				checkCtrl(ctrl, prevCtrl, "held during stall");
			end
			prevUop = expUop;
			prevCtrl = expCtrl;
			if (!stall) begin
				busy = !done; // Beat accepted at the next edge
				mBeat = done ? 0 : mBeat + 1;
				mList = nextList;
			end
			prevStall = stall;
		end
		$display("Checks %0d, uop errors %0d, ctrl errors %0d", checks, uopErrors, ctrlErrors);
		if (uopErrors + ctrlErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: rtl/blockTransferPlan.sv
// Load-multiple beat planner giving each beat's destination register, U bit and offset
`timescale 1ns/1ps

module blockTransferPlan (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic             loadList, // First beat, use instruction's own list
	input  isaPkg::instrWord instr,
	output uopPkg::blockBeat beat
);

	logic [isaPkg::regListWidth-1:0] remList;  // Registers still to load
	logic [isaPkg::regListWidth-1:0] curList;
	logic [isaPkg::regIdxWidth:0]    beatIdx;  // Index of the next beat
	logic [isaPkg::regIdxWidth:0]    curIdx;
	logic [isaPkg::regIdxWidth:0]    listCount; // Set bits in the full list
	logic [isaPkg::regIdxWidth-1:0]  lowReg;
	logic [7:0]                      listBytes;
	logic [7:0]                      stepBytes;
	logic signed [7:0]               startOff;  // Signed offset of beat 0
	logic signed [7:0]               curOff;
	logic [7:0]                      offMag;

	assign curList = loadList ? instr[isaPkg::regListWidth-1:0] : remList;
	assign curIdx = loadList ? '0 : beatIdx;
	assign listCount = 5'($countones(instr[isaPkg::regListWidth-1:0]));
	assign listBytes = 8'(listCount) * 8'(isaPkg::wordBytes);
	assign stepBytes = 8'(curIdx) * 8'(isaPkg::wordBytes);

	// Start offset from addressing mode P/U
	always_comb begin
		case (instr[24:23])
			2'b00: startOff = $signed(8'(isaPkg::wordBytes)) - $signed(listBytes); // DA
			2'b01: startOff = '0;                                               // IA
			2'b10: startOff = -$signed(listBytes);                              // DB
			default: startOff = $signed(8'(isaPkg::wordBytes));                 // IB
		endcase
	end

	assign curOff = startOff + $signed(stepBytes); // Each beat one word higher
	assign offMag = curOff[7] ? 8'(-curOff) : 8'(curOff);

	// Lowest set register in the working list
	always_comb begin
		lowReg = '0;
		for (int i = isaPkg::regListWidth - 1; i >= 0; i--) begin
			if (curList[i]) begin
				lowReg = 4'(i);
			end
		end
	end

	assign beat.destReg = lowReg;
	assign beat.upBit = !curOff[7]; // Zero offset counts as up
	assign beat.offset = {4'b0, offMag};
	assign beat.lastBeat = ($countones(curList) == 1);

	// State left after the beat just described
	always_ff @(posedge clk) begin
		if (reset) begin
			remList <= '0;
			beatIdx <= '0;
		end else if (!stall) begin
			remList <= curList & ~(16'b1 << lowReg); // Drop the loaded register
			beatIdx <= curIdx + 1'b1;
		end
	end

endmodule

// File: rtl/instrClassify.sv
// Combinational decode of the expansion class and condition check for the micro-op expander
`timescale 1ns/1ps

module instrClassify (
	input  isaPkg::instrWord  instr,
	input  isaPkg::nzcvFlags  flags,
	output isaPkg::instrClass cls,
	output logic              condPass
);

	logic isBx;    // BX Rm is never treated as RSR
	logic isRsr;
	logic isMulAcc;
	logic isLdm;
	logic isBl;
	isaPkg::condCode cond;

	assign cond = isaPkg::condCode'(instr[isaPkg::condLsb +: 4]);

	assign isBx = (instr[27:6] == {8'b0001_0010, 12'hFFF, 2'b00});
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4] && !isBx;
	assign isMulAcc = instr[21] && (instr[7:4] == 4'b1001); // MLA / UMLAL / SMLAL
	assign isLdm = (instr[27:25] == 3'b100) && instr[20]
		&& (instr[isaPkg::regListWidth-1:0] != '0); // Empty list passes through
	assign isBl = (instr[27:24] == 4'b1011);

	// RSR outranks multiply-accumulate, then LDM, then BL
	always_comb begin
		if (isRsr) begin
			cls = isaPkg::clsRsr;
		end else if (isMulAcc) begin
			cls = instr[23] ? isaPkg::clsMulAccLong : isaPkg::clsMulAccShort; // Bit 23 picks long
		end else if (isLdm) begin
			cls = isaPkg::clsLoadMultiple;
		end else if (isBl) begin
			cls = isaPkg::clsBranchLink;
		end else begin
			cls = isaPkg::clsPlain;
		end
	end

	// Condition evaluation against current NZCV
	always_comb begin
		condPass = 1'b0;
		case (cond)
			isaPkg::eq: condPass = flags.z;
			isaPkg::ne: condPass = !flags.z;
			isaPkg::cs: condPass = flags.c;
			isaPkg::cc: condPass = !flags.c;
			isaPkg::mi: condPass = flags.n;
			isaPkg::pl: condPass = !flags.n;
			isaPkg::vs: condPass = flags.v;
			isaPkg::vc: condPass = !flags.v;
			isaPkg::hi: condPass = flags.c && !flags.z;
			isaPkg::ls: condPass = !flags.c || flags.z;
			isaPkg::ge: condPass = (flags.n == flags.v);
			isaPkg::lt: condPass = (flags.n != flags.v);
			isaPkg::gt: condPass = !flags.z && (flags.n == flags.v);
			isaPkg::le: condPass = flags.z || (flags.n != flags.v);
			isaPkg::al: condPass = 1'b1;
			isaPkg::nv: condPass = 1'b0; // Never
			default: condPass = 1'b0;
		endcase
	end

endmodule

// File: rtl/isaPkg.sv
// Instruction-set types and field positions shared by the decode-side micro-op logic
package isaPkg;

	typedef logic [31:0] instrWord; // One ARM instruction word

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry
		logic v; // Overflow
	} nzcvFlags;

	// Condition field encodings, bits 31:28
	typedef enum logic [3:0] {
		eq, ne, cs, cc, mi, pl, vs, vc,
		hi, ls, ge, lt, gt, le, al, nv
	} condCode;

	// Data-processing opcode field, bits 24:21
	typedef enum logic [3:0] {
		andOp, eorOp, subOp, rsbOp, addOp, adcOp, sbcOp, rscOp,
		tstOp, teqOp, cmpOp, cmnOp, orrOp, movOp, bicOp, mvnOp
	} dpOpcode;

	// Expansion class picked by the classifier
	typedef enum logic [2:0] {
		clsPlain, clsRsr, clsMulAccShort, clsMulAccLong, clsBranchLink, clsLoadMultiple
	} instrClass;

	localparam int condLsb = 28; // Condition field
	localparam int rnLsb = 16;   // First operand / base register
	localparam int rdLsb = 12;   // Destination, Ra for MLA
	localparam int regIdxWidth = 4;
	localparam int regListWidth = 16; // LDM register list, bits 15:0

	localparam int wordBytes = 4; // Address step between LDM beats

endpackage

// File: rtl/microOpExpander.sv
// Top of the decode-stage micro-op expander, instantiated between fetch/decode and register read
`timescale 1ns/1ps

module microOpExpander (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  isaPkg::instrWord instr,
	input  isaPkg::nzcvFlags flags,
	output isaPkg::instrWord uop,
	output uopPkg::uopCtrl   ctrl
);

	isaPkg::instrClass cls;
	logic              condPass;
	logic              loadList; // Planner restarts from the instruction list
	uopPkg::blockBeat  beat;

	instrClassify u_instrClassify (
		.instr    (instr),
		.flags    (flags),
		.cls      (cls),
		.condPass (condPass)
	);

	blockTransferPlan u_blockTransferPlan (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.loadList (loadList),
		.instr    (instr),
		.beat     (beat)
	);

	uopSequencer u_uopSequencer (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.instr    (instr),
		.cls      (cls),
		.condPass (condPass),
		.beat     (beat),
		.loadList (loadList),
		.uop      (uop),
		.ctrl     (ctrl)
	);

endmodule

// File: rtl/uopPkg.sv
// Micro-op sequencing types and register numbers used by the expander and its testbench
package uopPkg;

	// Sequencer states; ready issues beat 1 of any series
	typedef enum logic [2:0] {
		ready, rsrOp, mulAccAdd, branchJump, ldmBeat
	} seqState;

	// Register-file Rz routing, same encodings the datapath decodes
	typedef enum logic [3:0] {
		rzNone     = 4'b0000,
		rzShiftSrc = 4'b1100, // RA1 mux plus Rz as write target
		rzOperandB = 4'b0010, // Rz read on port B
		rzOperandA = 4'b0001  // Rz read on port A
	} rzSelect;

	typedef struct packed {
		logic instrMux;     // Micro-op replaces the decoded word
		logic noFlagUpdate;
		logic uopStall;     // Decode must hold the instruction
		logic keepV;
		logic prevRsr;      // Second half of a two-beat op
		logic blockForward; // LDM beat after the first
		rzSelect rz;
	} uopCtrl;

	typedef struct packed {
		logic [3:0] destReg; // Lowest remaining listed register
		logic upBit;         // U bit of the single load
		logic [11:0] offset; // Offset magnitude
		logic lastBeat;      // Only one register left
	} blockBeat;

	localparam logic [3:0] rzReg = 4'hF;   // Scratch register
	localparam logic [3:0] linkReg = 4'hE; // LR
	localparam logic [3:0] pcReg = 4'hF;   // PC as source operand

endpackage

// File: rtl/uopSequencer.sv
// Mealy FSM building each micro-op word and its decode controls from the classified instruction
`timescale 1ns/1ps

module uopSequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  isaPkg::instrWord  instr,
	input  isaPkg::instrClass cls,
	input  logic              condPass,
	input  uopPkg::blockBeat  beat,
	output logic              loadList,
	output isaPkg::instrWord  uop,
	output uopPkg::uopCtrl    ctrl
);

	uopPkg::seqState state;
	uopPkg::seqState nextState;
	logic [3:0] cond;
	logic [3:0] rn;
	logic [3:0] ra;       // Accumulate register of MLA
	isaPkg::instrWord ldmWord;

	assign cond = instr[isaPkg::condLsb +: 4];
	assign rn = instr[isaPkg::rnLsb +: isaPkg::regIdxWidth];
	assign ra = instr[isaPkg::rdLsb +: isaPkg::regIdxWidth];
	assign loadList = (state == uopPkg::ready);

	// Single pre-indexed word load, no writeback
	assign ldmWord = {cond, 3'b010, 1'b1, beat.upBit, 1'b0, 1'b0, 1'b1,
		rn, beat.destReg, beat.offset};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::ready;
		end else if (!stall) begin
			state <= nextState; // Hold whole series while pipeline stalls
		end
	end

	always_comb begin
		uop = instr; // Pass-through unless replaced
		ctrl = '0;
		nextState = uopPkg::ready;
		case (state)
			uopPkg::ready: begin
				case (cls)
					isaPkg::clsRsr: begin
						uop = {instr[31:25], isaPkg::movOp, 1'b0, 4'b0000, uopPkg::rzReg,
							instr[11:0]}; // MOV Rz, shifted operand
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = 1'b1;
						ctrl.rz = uopPkg::rzShiftSrc;
						nextState = uopPkg::rsrOp;
					end
					isaPkg::clsMulAccShort, isaPkg::clsMulAccLong: begin
						uop = {instr[31:24], 1'b0, instr[22], 1'b0, instr[20], uopPkg::rzReg,
							4'b0000, instr[11:0]}; // Plain MUL into Rz
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
						ctrl.keepV = 1'b1;
						ctrl.rz = uopPkg::rzShiftSrc;
						nextState = uopPkg::mulAccAdd;
					end
					isaPkg::clsBranchLink: begin
						uop = {cond, 3'b000, isaPkg::movOp, 1'b0, 4'b0000, uopPkg::linkReg,
							8'b0, uopPkg::pcReg}; // MOV LR, PC
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
						nextState = uopPkg::branchJump;
					end
					isaPkg::clsLoadMultiple: begin
						uop = ldmWord; // First beat, condition checked downstream
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = !beat.lastBeat;
						nextState = beat.lastBeat ? uopPkg::ready : uopPkg::ldmBeat;
					end
					default: begin
						nextState = uopPkg::ready; // Plain, single beat
					end
				endcase
			end
			uopPkg::rsrOp: begin
				uop = {instr[31:12], 8'b0, uopPkg::rzReg}; // Original op on unshifted Rz
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rz = uopPkg::rzOperandB;
			end
			uopPkg::mulAccAdd: begin
				if (cls == isaPkg::clsMulAccLong) begin
					uop = {instr[31:24], 3'b101, instr[20:16], ra, ra, 4'b1001,
						instr[19:16]}; // Accumulate-long form
					ctrl.rz = uopPkg::rzNone;
				end else begin
					uop = {cond, 3'b000, isaPkg::addOp, instr[21], uopPkg::rzReg,
						instr[19:16], 8'b0, ra}; // ADD Rd, Rz, Ra
					ctrl.rz = uopPkg::rzOperandA;
				end
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.prevRsr = 1'b1;
			end
			uopPkg::branchJump: begin
				uop = {instr[31:25], 1'b0, instr[23:0]}; // B without link
				ctrl.instrMux = 1'b1;
			end
			uopPkg::ldmBeat: begin
				if (!condPass) begin
					uop = {cond, 3'b001, isaPkg::addOp, 1'b0, 20'b0}; // Abort, harmless ADD
					ctrl.noFlagUpdate = 1'b1;
				end else begin
					uop = ldmWord;
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.uopStall = !beat.lastBeat;
					ctrl.blockForward = 1'b1;
					nextState = beat.lastBeat ? uopPkg::ready : uopPkg::ldmBeat;
				end
			end
			default: begin
				nextState = uopPkg::ready;
			end
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the micro-op expander testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module microOpExpanderTb -Mdir obj_dir

out=$(./obj_dir/VmicroOpExpanderTb)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

// File: src.f
rtl/isaPkg.sv
rtl/uopPkg.sv
rtl/instrClassify.sv
rtl/blockTransferPlan.sv
rtl/uopSequencer.sv
rtl/microOpExpander.sv
bench/microOpExpanderTb.sv
